// File: src/cpu_pkg.sv
package cpu_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int data_w   = 16;
	localparam int reg_aw   = 3;
	localparam int num_regs = 8;
	localparam int imm_w    = 6;
	localparam int shamt_w  = 4;

	// ========================================
	// instruction encodings
	// ========================================
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_xor  = 4'd3,
		op_addi = 4'd4,
		op_sll  = 4'd5,
		op_srl  = 4'd6
	} opcode_t;

	typedef struct packed {
		opcode_t           opcode;
		logic [reg_aw-1:0] rd;
		logic [reg_aw-1:0] rs1;
		logic [reg_aw-1:0] rs2;
		logic [2:0]        unused;
	} instr_r_t;

	// shift amount sits in the low immediate bits.
	typedef struct packed {
		opcode_t                  opcode;
		logic [reg_aw-1:0]        rd;
		logic [reg_aw-1:0]        rs1;
		logic signed [imm_w-1:0]  imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		logic [reg_aw-1:0] rd;
		logic [data_w-1:0] value;
		logic              err;
	} result_t;

	typedef struct packed {
		opcode_t           opcode;
		logic [data_w-1:0] imm;
		logic              is_imm;
	} alu_op_t;

endpackage

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  logic [cpu_pkg::reg_aw-1:0] wr_addr,
	input  logic [cpu_pkg::data_w-1:0] wr_data,
	input  logic [cpu_pkg::reg_aw-1:0] rd1_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rd2_addr,
	output logic [cpu_pkg::data_w-1:0] rd1_data,
	output logic [cpu_pkg::data_w-1:0] rd2_data
);

	logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::num_regs];

	// ========================================
	// storage
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// ========================================
	// read ports
	// ========================================
	// plain muxes, no read latency.
	always_comb begin
		rd1_data = regs[rd1_addr];
	end

	always_comb begin
		rd2_data = regs[rd2_addr];
	end

	// a write is seen by a read of the same register one cycle later.

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       load,
	input  logic                       shift_step,
	input  cpu_pkg::alu_op_t           op,
	input  logic [cpu_pkg::data_w-1:0] opa,
	input  logic [cpu_pkg::data_w-1:0] opb,
	output logic [cpu_pkg::data_w-1:0] result
);

	logic [cpu_pkg::data_w-1:0] a_q;
	logic [cpu_pkg::data_w-1:0] b_q;
	logic [cpu_pkg::data_w-1:0] sh_q;
	logic [cpu_pkg::data_w-1:0] b_eff;

	// operand latch and shift register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_q  <= '0;
			b_q  <= '0;
			sh_q <= '0;
		end else if (load) begin
			a_q  <= opa;
			b_q  <= opb;
			sh_q <= opa;
		end else if (shift_step) begin
			if (op.opcode == cpu_pkg::op_srl) begin
				sh_q <= sh_q >> 1;
			end else begin
				sh_q <= sh_q << 1;
			end
		end
	end

	assign b_eff = op.is_imm ? op.imm : b_q;

	always_comb begin
		case (op.opcode)
			cpu_pkg::op_add,
			cpu_pkg::op_addi: result = a_q + b_eff;
			cpu_pkg::op_sub:  result = a_q - b_eff;
			cpu_pkg::op_and:  result = a_q & b_eff;
			cpu_pkg::op_xor:  result = a_q ^ b_eff;
			cpu_pkg::op_sll,
			cpu_pkg::op_srl:  result = sh_q;
			default:          result = '0;
		endcase
	end

endmodule

// File: src/shift_counter.sv
`timescale 1ns/1ps

module shift_counter (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        load,
	input  logic [cpu_pkg::shamt_w-1:0] amount,
	input  logic                        step,
	output logic                        done
);

	logic [cpu_pkg::shamt_w-1:0] count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= amount;
		end else if (step && count != '0) begin
			count <= count - 1'b1;
		end
	end

	// zero amount finishes at once, else on the last step.
	assign done = (count == '0) || (step && count == 1);

endmodule

// File: src/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid,
	input  cpu_pkg::instr_u             in_instr,
	output logic                        in_ready,
	output logic                        out_valid,
	input  logic                        out_ready,
	output cpu_pkg::result_t            out_result,
	output logic [cpu_pkg::reg_aw-1:0]  rd1_addr,
	output logic [cpu_pkg::reg_aw-1:0]  rd2_addr,
	output cpu_pkg::alu_op_t            alu_op,
	output logic                        alu_load,
	output logic                        shift_step,
	output logic                        cnt_load,
	output logic [cpu_pkg::shamt_w-1:0] cnt_amount,
	input  logic                        shift_done,
	input  logic [cpu_pkg::data_w-1:0]  alu_result,
	output logic                        wr_en,
	output logic [cpu_pkg::reg_aw-1:0]  wr_addr,
	output logic [cpu_pkg::data_w-1:0]  wr_data
);

	typedef enum logic [2:0] {s_idle, s_read, s_exec, s_wb, s_resp} state_t;

	state_t            state;
	state_t            state_next;
	cpu_pkg::instr_u   instr_q;
	cpu_pkg::opcode_t  opcode;
	logic              is_imm;
	logic              is_shift;
	logic              illegal;

	// ========================================
	// decode
	// ========================================
	assign opcode     = instr_q.r.opcode;
	assign is_shift   = (opcode == cpu_pkg::op_sll) || (opcode == cpu_pkg::op_srl);
	assign is_imm     = is_shift || (opcode == cpu_pkg::op_addi);
	assign illegal    = !(is_imm || opcode inside {cpu_pkg::op_add, cpu_pkg::op_sub,
		cpu_pkg::op_and, cpu_pkg::op_xor});
	assign cnt_amount = instr_q.i.imm[cpu_pkg::shamt_w-1:0];

	assign rd1_addr = instr_q.r.rs1;
	assign rd2_addr = instr_q.r.rs2;

	always_comb begin
		alu_op.opcode = opcode;
		alu_op.imm    = {{(cpu_pkg::data_w - cpu_pkg::imm_w){instr_q.i.imm[cpu_pkg::imm_w-1]}},
			instr_q.i.imm};
		alu_op.is_imm = is_imm;
	end

	// ========================================
	// sequencing
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			s_idle: if (in_valid && in_ready) state_next = s_read;
			s_read: state_next = illegal ? s_wb : s_exec;
			s_exec: if (!is_shift || shift_done) state_next = s_wb;
			s_wb:   state_next = s_resp;
			s_resp: if (out_ready) state_next = s_idle;
			default: state_next = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= s_idle;
			in_ready  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			state     <= state_next;
			in_ready  <= (state_next == s_idle);
			out_valid <= (state_next == s_resp);
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			instr_q <= in_instr;
		end
	end

	assign alu_load   = (state == s_read);
	assign cnt_load   = (state == s_read) && is_shift;
	assign shift_step = (state == s_exec) && is_shift && (cnt_amount != '0);

	// write-back, dropped for an unknown opcode.
	assign wr_en   = (state == s_wb) && !illegal;
	assign wr_addr = instr_q.r.rd;
	assign wr_data = alu_result;

	always_ff @(posedge clk) begin
		if (state == s_wb) begin
			out_result.rd    <= instr_q.r.rd;
			out_result.value <= illegal ? '0 : alu_result;
			out_result.err   <= illegal;
		end
	end

endmodule

// File: src/cpu_exec.sv
`timescale 1ns/1ps

module cpu_exec (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  cpu_pkg::instr_u  in_instr,
	output logic             out_valid,
	input  logic             out_ready,
	output cpu_pkg::result_t out_result
);

	logic [cpu_pkg::reg_aw-1:0]  rd1_addr;
	logic [cpu_pkg::reg_aw-1:0]  rd2_addr;
	logic [cpu_pkg::data_w-1:0]  rd1_data;
	logic [cpu_pkg::data_w-1:0]  rd2_data;
	cpu_pkg::alu_op_t            alu_op;
	logic                        alu_load;
	logic                        shift_step;
	logic                        cnt_load;
	logic [cpu_pkg::shamt_w-1:0] cnt_amount;
	logic                        shift_done;
	logic [cpu_pkg::data_w-1:0]  alu_result;
	logic                        wr_en;
	logic [cpu_pkg::reg_aw-1:0]  wr_addr;
	logic [cpu_pkg::data_w-1:0]  wr_data;

	exec_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result),
		.rd1_addr   (rd1_addr),
		.rd2_addr   (rd2_addr),
		.alu_op     (alu_op),
		.alu_load   (alu_load),
		.shift_step (shift_step),
		.cnt_load   (cnt_load),
		.cnt_amount (cnt_amount),
		.shift_done (shift_done),
		.alu_result (alu_result),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	shift_counter u_cnt (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (cnt_load),
		.amount (cnt_amount),
		.step   (shift_step),
		.done   (shift_done)
	);

	alu u_alu (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (alu_load),
		.shift_step (shift_step),
		.op         (alu_op),
		.opa        (rd1_data),
		.opb        (rd2_data),
		.result     (alu_result)
	);

	reg_file u_rf (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd1_addr (rd1_addr),
		.rd2_addr (rd2_addr),
		.rd1_data (rd1_data),
		.rd2_data (rd2_data)
	);

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period = 10;
	localparam int rst_cycles  = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// release on a falling edge, away from the flops.
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: tests/cpu_exec_sva.sv
`timescale 1ns/1ps

module cpu_exec_sva (
	input logic             clk,
	input logic             rst_n,
	input logic             in_ready,
	input logic             out_valid,
	input logic             out_ready,
	input cpu_pkg::result_t out_result
);

	int unsigned fail_count = 0;

	// ========================================
	// handshake rules
	// ========================================
	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!in_ready && !out_valid))
		else begin
			fail_count++;
			$error("in_ready or out_valid high during reset");
		end

	result_held: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> $stable(out_result))
		else begin
			fail_count++;
			$error("out_result changed while waiting for out_ready");
		end

	// one instruction in flight.
	ready_or_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_ready && out_valid))
		else begin
			fail_count++;
			$error("in_ready and out_valid high together");
		end

endmodule

bind cpu_exec cpu_exec_sva sva0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_result (out_result)
);

// File: tests/cpu_exec_tb.sv
`timescale 1ns/1ps

module cpu_exec_tb;

	localparam int rst_cycles  = 16;
	localparam int num_instr   = 64;
	localparam int cycle_limit = rst_cycles + 40 * num_instr;

	logic                       clk;
	logic                       rst_n;
	logic                       in_valid;
	logic                       in_ready;
	cpu_pkg::instr_u            in_instr;
	logic                       out_valid;
	logic                       out_ready;
	cpu_pkg::result_t           out_result;
	logic [cpu_pkg::data_w-1:0] model_regs [cpu_pkg::num_regs];
	int                         cycles = 0;

	clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

	cpu_exec dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_instr   (in_instr),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	// failures of the bound checker.
	always @(dut0.sva0.fail_count) begin
		if (dut0.sva0.fail_count != 0) begin
			$display("a handshake assertion in the bound checker failed");
			$display("test failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("test failed");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic cpu_pkg::instr_u encode_r(input logic [3:0] op, input logic [2:0] rd,
		input logic [2:0] rs1, input logic [2:0] rs2);
		return cpu_pkg::instr_u'({op, rd, rs1, rs2, 3'b000});
	endfunction

	function automatic cpu_pkg::instr_u encode_i(input logic [3:0] op, input logic [2:0] rd,
		input logic [2:0] rs1, input logic [5:0] imm);
		return cpu_pkg::instr_u'({op, rd, rs1, imm});
	endfunction

	// ========================================
	// reference model
	// ========================================
	function automatic cpu_pkg::result_t predict_result(input cpu_pkg::instr_u ins);
		cpu_pkg::result_t res;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm_ext;
		a = model_regs[ins.r.rs1];
		b = model_regs[ins.r.rs2];
		imm_ext = {{10{ins.i.imm[5]}}, ins.i.imm};
		res.rd = ins.r.rd;
		res.err = 1'b0;
		res.value = '0;
		case (ins.r.opcode)
			cpu_pkg::op_add:  res.value = a + b;
			cpu_pkg::op_sub:  res.value = a - b;
			cpu_pkg::op_and:  res.value = a & b;
			cpu_pkg::op_xor:  res.value = a ^ b;
			cpu_pkg::op_addi: res.value = a + imm_ext;
			cpu_pkg::op_sll:  res.value = a << ins.i.imm[3:0];
			cpu_pkg::op_srl:  res.value = a >> ins.i.imm[3:0];
			default:          res.err = 1'b1;
		endcase
		return res;
	endfunction

	// one instruction end to end with optional back-pressure stalls.
	task automatic issue_and_check(input string name, input cpu_pkg::instr_u ins,
		input int stall);
		cpu_pkg::result_t expected;
		cpu_pkg::result_t got;
		logic [3:0] shamt;
		int accept_cycle;
		int latency;
		int want_latency;
		expected = predict_result(ins);
		shamt = ins.i.imm[3:0];
		@(posedge clk);
		in_valid <= 1'b1;
		in_instr <= ins;
		out_ready <= (stall == 0);
		@(negedge clk);
		while (!in_ready) @(negedge clk);
		@(posedge clk);
		in_valid <= 1'b0;
		@(negedge clk);
		accept_cycle = cycles;
		compare({name, " in_ready after accept"}, 32'd0, 32'(in_ready));
		while (!out_valid) @(negedge clk);
		latency = cycles - accept_cycle;
		got = out_result;
		repeat (stall) begin
			@(negedge clk);
			compare({name, " out_valid held"}, 32'd1, 32'(out_valid));
			compare({name, " out_result held"}, 32'(got), 32'(out_result));
			compare({name, " in_ready while stalled"}, 32'd0, 32'(in_ready));
		end
		if (stall > 0) begin
			@(posedge clk);
			out_ready <= 1'b1;
		end
		@(posedge clk);
		@(negedge clk);
		compare({name, " out_valid after transfer"}, 32'd0, 32'(out_valid));
		compare({name, " in_ready after transfer"}, 32'd1, 32'(in_ready));
		compare({name, " rd"}, 32'(expected.rd), 32'(got.rd));
		compare({name, " err"}, 32'(expected.err), 32'(got.err));
		if (!expected.err) begin
			compare({name, " value"}, 32'(expected.value), 32'(got.value));
			model_regs[expected.rd] = expected.value;
			if (ins.r.opcode == cpu_pkg::op_sll || ins.r.opcode == cpu_pkg::op_srl) begin
				want_latency = 2 + ((shamt == 4'd0) ? 1 : int'(shamt));
			end else begin
				want_latency = 3;
			end
			compare({name, " latency"}, 32'(want_latency), 32'(latency));
		end
	endtask

	// ========================================
	// directed tests
	// ========================================
	task automatic reset_regs_read_zero();
		for (int i = 0; i < cpu_pkg::num_regs; i++) begin
			issue_and_check("reset_zero", encode_r(cpu_pkg::op_add, 3'(i), 3'(i), 3'd0), 0);
		end
	endtask

	task automatic alu_ops_match_model();
		logic [3:0] op;
		for (int i = 0; i < cpu_pkg::num_regs; i++) begin
			issue_and_check("addi_load",
				encode_i(cpu_pkg::op_addi, 3'(i), 3'(i), 6'($urandom)), 0);
		end
		repeat (16) begin
			case ($urandom_range(3))
				0:       op = cpu_pkg::op_add;
				1:       op = cpu_pkg::op_sub;
				2:       op = cpu_pkg::op_and;
				default: op = cpu_pkg::op_xor;
			endcase
			issue_and_check("reg_ops",
				encode_r(op, 3'($urandom), 3'($urandom), 3'($urandom)), 0);
		end
	endtask

	task automatic shifts_match_model();
		logic [3:0] op;
		logic [3:0] shamt;
		for (int i = 0; i < 16; i++) begin
			op = ($urandom_range(1) == 0) ? cpu_pkg::op_sll : cpu_pkg::op_srl;
			// first two cover a zero shift.
			shamt = (i < 2) ? 4'd0 : 4'($urandom_range(15));
			issue_and_check("shifts",
				encode_i(op, 3'($urandom), 3'($urandom), {2'($urandom), shamt}), 0);
		end
	endtask

	task automatic illegal_opcode_keeps_reg();
		logic [2:0] rd;
		repeat (3) begin
			rd = 3'($urandom);
			issue_and_check("illegal",
				encode_r(4'($urandom_range(15, 7)), rd, 3'($urandom), 3'($urandom)), 0);
			// addi of zero reads rd back.
			issue_and_check("illegal_readback", encode_i(cpu_pkg::op_addi, rd, rd, 6'd0), 0);
		end
	endtask

	task automatic backpressure_holds_result();
		repeat (10) begin
			issue_and_check("backpressure",
				encode_i(4'($urandom_range(6)), 3'($urandom), 3'($urandom), 6'($urandom)),
				$urandom_range(8, 1));
		end
	endtask

	initial begin
		in_valid <= 1'b0;
		in_instr <= '0;
		out_ready <= 1'b1;
		for (int i = 0; i < cpu_pkg::num_regs; i++) begin
			model_regs[i] = '0;
		end
		void'($urandom(94));
		@(negedge rst_n);
		@(posedge rst_n);
		reset_regs_read_zero();
		alu_ops_match_model();
		shifts_match_model();
		illegal_opcode_keeps_reg();
		backpressure_holds_result();
		$display("test passed");
		$finish;
	end

endmodule

// File: cpu_exec.f
src/cpu_pkg.sv
src/reg_file.sv
src/alu.sv
src/shift_counter.sv
src/exec_ctrl.sv
src/cpu_exec.sv
tests/clk_gen.sv
tests/cpu_exec_sva.sv
tests/cpu_exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_exec_tb
FILELIST  ?= cpu_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
